/* hdl/arya_isa_pkg.sv */
`default_nettype none

package arya_isa_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;

	// datapath word, same width as apb data
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WORD_W-1:0] inst_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	// 256 instruction words
	typedef logic [7:0] imem_addr_t;

	//////////////////////////////
	// instruction format
	//////////////////////////////

	// opcode in the top six bits
	localparam int OPCODE_LSB = 26;
	localparam int RD_LSB     = 21;
	localparam int RS1_LSB    = 16;
	localparam int RS2_LSB    = 11;
	// immediate sits in the low bits
	localparam int IMM_W      = 16;

	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_ADDI = 6'd8,
		OP_HALT = 6'd63
	} opcode_e;

	// alu function select
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_e;

endpackage

`default_nettype wire

/* hdl/arya_regmap_pkg.sv */
`default_nettype none

package arya_regmap_pkg;

	typedef logic [11:0] paddr_t;

	//////////////////////////////
	// address windows
	//////////////////////////////

	// imem window, 256 words from 0x000
	localparam paddr_t IMEM_BASE   = 12'h000;
	localparam paddr_t IMEM_MASK   = 12'hC00;
	// register window, 32 words from 0x400
	localparam paddr_t REG_BASE    = 12'h400;
	localparam paddr_t REG_MASK    = 12'hF80;
	localparam paddr_t CTRL_ADDR   = 12'h800;
	localparam paddr_t STATUS_ADDR = 12'h804;

	// ctrl and status bits
	localparam int CTRL_START_BIT  = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

	// run state of the core
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DRAIN,
		SEQ_DONE
	} seq_state_e;

endpackage

`default_nettype wire

/* hdl/arya_issue_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one decoded instruction on its way from decode to execute
interface arya_issue_if;

	logic                   valid;
	arya_isa_pkg::alu_op_e  alu_op;
	arya_isa_pkg::word_t    opa;
	// already muxed with the immediate
	arya_isa_pkg::word_t    opb;
	arya_isa_pkg::reg_addr_t rd;
	logic                   wr_en;

	// decode side
	modport issue (
		output valid, alu_op, opa, opb, rd, wr_en
	);

	// execute side, takes every valid item
	modport exec (
		input valid, alu_op, opa, opb, rd, wr_en
	);

endinterface

`default_nettype wire

/* hdl/arya_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module arya_sequencer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  arya_regmap_pkg::paddr_t     paddr,
	input  arya_isa_pkg::word_t         pwdata,
	output arya_isa_pkg::word_t         prdata,
	output logic                        pready,
	output logic                        pslverr,
	input  logic                        halt_seen,
	input  logic                        pipe_empty,
	output logic                        issue_en,
	output logic                        pc_clear,
	output arya_isa_pkg::imem_addr_t    imem_host_addr,
	output arya_isa_pkg::word_t         imem_host_wdata,
	output logic                        imem_host_we,
	input  arya_isa_pkg::word_t         imem_host_rdata,
	output arya_isa_pkg::reg_addr_t     reg_host_addr,
	input  arya_isa_pkg::word_t         reg_host_rdata
);

	arya_regmap_pkg::seq_state_e state;
	arya_regmap_pkg::seq_state_e state_nxt;
	logic access;
	logic busy;
	logic done;
	logic in_imem;
	logic in_reg;
	logic in_ctrl;
	logic in_status;
	logic start_req;
	logic err;

	//////////////////////////////
	// apb decode
	//////////////////////////////

	// second cycle of a transfer
	assign access = psel & penable;
	assign busy   = (state == arya_regmap_pkg::SEQ_RUN) || (state == arya_regmap_pkg::SEQ_DRAIN);
	assign done   = (state == arya_regmap_pkg::SEQ_DONE);

	assign in_imem   = (paddr & arya_regmap_pkg::IMEM_MASK) == arya_regmap_pkg::IMEM_BASE;
	assign in_reg    = (paddr & arya_regmap_pkg::REG_MASK) == arya_regmap_pkg::REG_BASE;
	assign in_ctrl   = (paddr == arya_regmap_pkg::CTRL_ADDR);
	assign in_status = (paddr == arya_regmap_pkg::STATUS_ADDR);

	assign start_req = access & pwrite & in_ctrl & pwdata[arya_regmap_pkg::CTRL_START_BIT];

	// unmapped, write to regs, window access or start while running
	assign err = !(in_imem | in_reg | in_ctrl | in_status)
		| (pwrite & in_reg)
		| (busy & (in_imem | in_reg))
		| (busy & start_req);

	assign pready  = access;
	assign pslverr = access & err;

	// word index, valid already in setup so the sync read lands in access
	assign imem_host_addr  = paddr[9:2];
	assign imem_host_wdata = pwdata;
	assign imem_host_we    = access & pwrite & in_imem & !err;
	assign reg_host_addr   = paddr[6:2];

	always_comb begin
		prdata = '0;
		if (in_imem) begin
			prdata = imem_host_rdata;
		end else if (in_reg) begin
			prdata = reg_host_rdata;
		end else if (in_status) begin
			prdata[arya_regmap_pkg::STATUS_BUSY_BIT] = busy;
			prdata[arya_regmap_pkg::STATUS_DONE_BIT] = done;
		end
	end

	//////////////////////////////
	// run state machine
	//////////////////////////////

	// pc goes to 0 on the same edge that enters RUN
	assign pc_clear = start_req & !busy;
	assign issue_en = (state == arya_regmap_pkg::SEQ_RUN);

	always_comb begin
		state_nxt = state;
		case (state)
			arya_regmap_pkg::SEQ_IDLE,
			arya_regmap_pkg::SEQ_DONE: if (start_req) state_nxt = arya_regmap_pkg::SEQ_RUN;
			arya_regmap_pkg::SEQ_RUN: if (halt_seen) state_nxt = arya_regmap_pkg::SEQ_DRAIN;
			// wait for the last writeback
			arya_regmap_pkg::SEQ_DRAIN: if (pipe_empty) state_nxt = arya_regmap_pkg::SEQ_DONE;
			default: state_nxt = arya_regmap_pkg::SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= arya_regmap_pkg::SEQ_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// apb protocol from the host
	a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel);

	// only a halt from decode ends the run
	a_run_exit: assert property (@(posedge clk) disable iff (!rst_n)
		(state == arya_regmap_pkg::SEQ_RUN && !halt_seen) |=> state == arya_regmap_pkg::SEQ_RUN);

endmodule

`default_nettype wire

/* hdl/arya_pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module arya_pc_counter #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     clear,
	input  logic                     advance,
	output arya_isa_pkg::imem_addr_t pc
);

	// last fetch address before the wrap
	localparam arya_isa_pkg::imem_addr_t PC_LAST = arya_isa_pkg::imem_addr_t'(IMEM_DEPTH - 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (clear) begin
			pc <= '0;
		end else if (advance) begin
			if (pc == PC_LAST) begin
				pc <= '0;
			end else begin
				pc <= pc + 1'b1;
			end
		end
		// otherwise hold
	end

	// start only comes while the core is stopped
	a_clear_advance: assert property (@(posedge clk) disable iff (!rst_n) !(clear && advance));

endmodule

`default_nettype wire

/* hdl/arya_imem.sv */
`timescale 1ns/1ps
`default_nettype none

module arya_imem #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                     clk,
	input  arya_isa_pkg::imem_addr_t fetch_addr,
	output arya_isa_pkg::inst_t      fetch_data,
	input  arya_isa_pkg::imem_addr_t host_addr,
	input  arya_isa_pkg::word_t      host_wdata,
	input  logic                     host_we,
	output arya_isa_pkg::word_t      host_rdata
);

	// program storage, kept across reset
	arya_isa_pkg::word_t mem [IMEM_DEPTH];

	// fetch port, read only
	// data one cycle after the address
	always_ff @(posedge clk) begin
		fetch_data <= mem[fetch_addr];
	end

	// host port
	// read returns the old word on a write cycle
	always_ff @(posedge clk) begin
		if (host_we) begin
			mem[host_addr] <= host_wdata;
		end
		host_rdata <= mem[host_addr];
	end

endmodule

`default_nettype wire

/* hdl/arya_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arya_regfile #(
	parameter int NUM_REGS = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  arya_isa_pkg::reg_addr_t rs1,
	input  arya_isa_pkg::reg_addr_t rs2,
	output arya_isa_pkg::word_t     rs1_data,
	output arya_isa_pkg::word_t     rs2_data,
	input  logic                    wb_en,
	input  arya_isa_pkg::reg_addr_t wb_addr,
	input  arya_isa_pkg::word_t     wb_data,
	input  arya_isa_pkg::reg_addr_t host_addr,
	output arya_isa_pkg::word_t     host_data
);

	arya_isa_pkg::word_t regs [NUM_REGS];

	// all registers clear on reset, a start leaves them alone
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// operand ports for decode
	// no bypass of a same-cycle write
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	// readback over apb
	assign host_data = regs[host_addr];

endmodule

`default_nettype wire

/* hdl/arya_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module arya_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  arya_isa_pkg::inst_t     inst,
	input  logic                    issue_en,
	output arya_isa_pkg::reg_addr_t rs1,
	output arya_isa_pkg::reg_addr_t rs2,
	input  arya_isa_pkg::word_t     rs1_data,
	input  arya_isa_pkg::word_t     rs2_data,
	output logic                    halt_seen,
	arya_issue_if.issue             issue
);

	arya_isa_pkg::opcode_e   opcode;
	arya_isa_pkg::reg_addr_t rd;
	arya_isa_pkg::alu_op_e   alu_op;
	arya_isa_pkg::word_t     imm_ext;
	logic alu_inst;
	logic use_imm;
	logic fetch_valid;

	//////////////////////////////
	// field split
	//////////////////////////////

	// straight off the imem output, there is no fetch register
	assign opcode = arya_isa_pkg::opcode_e'(inst[arya_isa_pkg::OPCODE_LSB +: arya_isa_pkg::OPCODE_W]);
	assign rd     = inst[arya_isa_pkg::RD_LSB +: arya_isa_pkg::REG_ADDR_W];
	assign rs1    = inst[arya_isa_pkg::RS1_LSB +: arya_isa_pkg::REG_ADDR_W];
	assign rs2    = inst[arya_isa_pkg::RS2_LSB +: arya_isa_pkg::REG_ADDR_W];

	// sign extend the immediate
	assign imm_ext = {{(arya_isa_pkg::WORD_W - arya_isa_pkg::IMM_W){inst[arya_isa_pkg::IMM_W-1]}},
		inst[arya_isa_pkg::IMM_W-1:0]};

	// opcode to alu function
	always_comb begin
		alu_op   = arya_isa_pkg::ALU_ADD;
		alu_inst = 1'b1;
		use_imm  = 1'b0;
		case (opcode)
			arya_isa_pkg::OP_ADD: alu_op = arya_isa_pkg::ALU_ADD;
			arya_isa_pkg::OP_SUB: alu_op = arya_isa_pkg::ALU_SUB;
			arya_isa_pkg::OP_AND: alu_op = arya_isa_pkg::ALU_AND;
			arya_isa_pkg::OP_OR:  alu_op = arya_isa_pkg::ALU_OR;
			arya_isa_pkg::OP_XOR: alu_op = arya_isa_pkg::ALU_XOR;
			arya_isa_pkg::OP_ADDI: begin
				alu_op  = arya_isa_pkg::ALU_ADD;
				use_imm = 1'b1;
			end
			// nop, halt and unknown codes write nothing
			default: alu_inst = 1'b0;
		endcase
	end

	//////////////////////////////
	// fetch qualify
	//////////////////////////////

	// imem lags the pc by a cycle
	// so the word seen in the first RUN cycle is stale
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= issue_en;
		end
	end

	assign halt_seen = issue_en & fetch_valid & (opcode == arya_isa_pkg::OP_HALT);

	//////////////////////////////
	// decode/execute register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= issue_en & fetch_valid & alu_inst;
		end
	end

	// payload, only meaningful with valid
	always_ff @(posedge clk) begin
		issue.alu_op <= alu_op;
		issue.opa    <= rs1_data;
		issue.opb    <= use_imm ? imm_ext : rs2_data;
		issue.rd     <= rd;
		issue.wr_en  <= alu_inst;
	end

endmodule

`default_nettype wire

/* hdl/arya_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module arya_execute (
	input  logic                    clk,
	input  logic                    rst_n,
	arya_issue_if.exec              issue,
	output logic                    wb_en,
	output arya_isa_pkg::reg_addr_t wb_addr,
	output arya_isa_pkg::word_t     wb_data,
	output logic                    pipe_empty
);

	arya_isa_pkg::word_t result;

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb begin
		case (issue.alu_op)
			arya_isa_pkg::ALU_ADD: result = issue.opa + issue.opb;
			arya_isa_pkg::ALU_SUB: result = issue.opa - issue.opb;
			arya_isa_pkg::ALU_AND: result = issue.opa & issue.opb;
			arya_isa_pkg::ALU_OR:  result = issue.opa | issue.opb;
			arya_isa_pkg::ALU_XOR: result = issue.opa ^ issue.opb;
			default:               result = '0;
		endcase
	end

	//////////////////////////////
	// execute/writeback register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_en <= 1'b0;
		end else begin
			wb_en <= issue.valid & issue.wr_en;
		end
	end

	// regfile takes these on the following edge
	always_ff @(posedge clk) begin
		wb_addr <= issue.rd;
		wb_data <= result;
	end

	// nothing in flight past decode
	assign pipe_empty = !issue.valid & !wb_en;

	// a stray X here would corrupt the regfile
	a_wb_en_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(wb_en));

endmodule

`default_nettype wire

/* hdl/arya.sv */
`timescale 1ns/1ps
`default_nettype none

module arya #(
	parameter int IMEM_DEPTH = 256,
	parameter int NUM_REGS   = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// apb slave
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  arya_regmap_pkg::paddr_t paddr,
	input  arya_isa_pkg::word_t     pwdata,
	output arya_isa_pkg::word_t     prdata,
	output logic                    pready,
	output logic                    pslverr
);

	// control
	logic halt_seen;
	logic pipe_empty;
	logic issue_en;
	logic pc_clear;

	// fetch
	arya_isa_pkg::imem_addr_t pc;
	arya_isa_pkg::inst_t      fetch_data;

	// host side
	arya_isa_pkg::imem_addr_t imem_host_addr;
	arya_isa_pkg::word_t      imem_host_wdata;
	logic                     imem_host_we;
	arya_isa_pkg::word_t      imem_host_rdata;
	arya_isa_pkg::reg_addr_t  reg_host_addr;
	arya_isa_pkg::word_t      reg_host_rdata;

	// operands and writeback
	arya_isa_pkg::reg_addr_t rs1;
	arya_isa_pkg::reg_addr_t rs2;
	arya_isa_pkg::word_t     rs1_data;
	arya_isa_pkg::word_t     rs2_data;
	logic                    wb_en;
	arya_isa_pkg::reg_addr_t wb_addr;
	arya_isa_pkg::word_t     wb_data;

	arya_issue_if issue_bus ();

	//////////////////////////////
	// control and fetch
	//////////////////////////////

	arya_sequencer seq (
		.clk             (clk),
		.rst_n           (rst_n),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.halt_seen       (halt_seen),
		.pipe_empty      (pipe_empty),
		.issue_en        (issue_en),
		.pc_clear        (pc_clear),
		.imem_host_addr  (imem_host_addr),
		.imem_host_wdata (imem_host_wdata),
		.imem_host_we    (imem_host_we),
		.imem_host_rdata (imem_host_rdata),
		.reg_host_addr   (reg_host_addr),
		.reg_host_rdata  (reg_host_rdata)
	);

	// pc steps whenever decode may issue
	arya_pc_counter #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) pc_cnt (
		.clk     (clk),
		.rst_n   (rst_n),
		.clear   (pc_clear),
		.advance (issue_en),
		.pc      (pc)
	);

	arya_imem #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) imem (
		.clk        (clk),
		.fetch_addr (pc),
		.fetch_data (fetch_data),
		.host_addr  (imem_host_addr),
		.host_wdata (imem_host_wdata),
		.host_we    (imem_host_we),
		.host_rdata (imem_host_rdata)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////

	arya_decode dec (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst      (fetch_data),
		.issue_en  (issue_en),
		.rs1       (rs1),
		.rs2       (rs2),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.halt_seen (halt_seen),
		.issue     (issue_bus.issue)
	);

	arya_regfile #(
		.NUM_REGS (NUM_REGS)
	) rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.rs1       (rs1),
		.rs2       (rs2),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.wb_en     (wb_en),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.host_addr (reg_host_addr),
		.host_data (reg_host_rdata)
	);

	arya_execute exe (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue_bus.exec),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.pipe_empty (pipe_empty)
	);

endmodule

`default_nettype wire

/* verif/arya_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module arya_tb;

	localparam int PROG_LEN     = 48;
	localparam int PREADY_LIMIT = 8;
	localparam int POLL_LIMIT   = 400;

	// apb address map
	localparam logic [11:0] REG_WIN  = 12'h400;
	localparam logic [11:0] CTRL     = 12'h800;
	localparam logic [11:0] STATUS   = 12'h804;
	localparam logic [11:0] UNMAPPED = 12'hC00;

	// opcodes, bits 31..26
	localparam logic [5:0] OP_NOP   = 6'd0;
	localparam logic [5:0] OP_ADD   = 6'd1;
	localparam logic [5:0] OP_SUB   = 6'd2;
	localparam logic [5:0] OP_AND   = 6'd3;
	localparam logic [5:0] OP_OR    = 6'd4;
	localparam logic [5:0] OP_XOR   = 6'd5;
	localparam logic [5:0] OP_ADDI  = 6'd8;
	localparam logic [5:0] OP_UNDEF = 6'd20;
	localparam logic [5:0] OP_HALT  = 6'd63;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] lfsr_state;
	// mirror of imem and the reference register state
	logic [31:0] exp_mem [256];
	logic [31:0] exp_regs [32];
	// targets of the writes placed after halt
	logic [4:0]  cut_rd [3];
	int          errors;
	int          test_start_errors;
	int          tests_run;
	int          tests_failed;
	logic        timed_out;

	arya arya_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// random numbers and checks
	//////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - test_start_errors);
		end
	endtask

	//////////////////////////////
	// apb driver
	//////////////////////////////

	// setup then access, sampled at the falling edge
	task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int n;
		rdata = '0;
		err = 1'b0;
		if (!timed_out) begin
			@(posedge clk);
			psel <= 1'b1;
			penable <= 1'b0;
			pwrite <= wr;
			paddr <= addr;
			pwdata <= wdata;
			@(posedge clk);
			penable <= 1'b1;
			@(negedge clk);
			n = 0;
			while (!pready && n < PREADY_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (!pready) begin
				$display("timeout: no pready for address %h", addr);
				timed_out = 1'b1;
				errors++;
			end
			rdata = prdata;
			err = pslverr;
			@(posedge clk);
			psel <= 1'b0;
			penable <= 1'b0;
		end
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	// poll status until done comes up
	task automatic wait_done();
		logic [31:0] st;
		logic err;
		int n;
		st = '0;
		n = 0;
		while (!st[1] && !timed_out && n < POLL_LIMIT) begin
			apb_read(STATUS, st, err);
			n++;
		end
		if (!st[1] && !timed_out) begin
			$display("timeout: core never reported done");
			timed_out = 1'b1;
			errors++;
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	// one instruction at a time, stops at halt
	task automatic run_model();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		int pc;
		logic halted;
		pc = 0;
		halted = 1'b0;
		while (!halted && pc < 256) begin
			w = exp_mem[pc];
			a = exp_regs[w[20:16]];
			b = (w[31:26] == OP_ADDI) ? {{16{w[15]}}, w[15:0]} : exp_regs[w[15:11]];
			case (w[31:26])
				OP_ADD, OP_ADDI: exp_regs[w[25:21]] = a + b;
				OP_SUB: exp_regs[w[25:21]] = a - b;
				OP_AND: exp_regs[w[25:21]] = a & b;
				OP_OR:  exp_regs[w[25:21]] = a | b;
				OP_XOR: exp_regs[w[25:21]] = a ^ b;
				OP_HALT: halted = 1'b1;
				// nop and unknown codes
				default: ;
			endcase
			pc++;
		end
	endtask

	task automatic check_regs(input string name);
		logic [31:0] data;
		logic err;
		for (int i = 0; i < 32; i++) begin
			apb_read(REG_WIN + 12'(i * 4), data, err);
			compare($sformatf("%s r%0d", name, i), exp_regs[i], data);
			compare($sformatf("%s r%0d pslverr", name, i), 32'd0, 32'(err));
		end
	endtask

	task automatic write_inst(input int idx, input logic [31:0] word);
		logic err;
		exp_mem[idx] = word;
		apb_write(12'(idx * 4), word, err);
		compare("random program load pslverr", 32'd0, 32'(err));
	endtask

	// source register not written by the two previous instructions
	function automatic logic [4:0] pick_source(input int last1, input int last2);
		logic [4:0] r;
		r = 5'(rand_bits(5));
		while (int'(r) == last1 || int'(r) == last2) begin
			r = 5'(rand_bits(5));
		end
		return r;
	endfunction

	task automatic load_program();
		int last1;
		int last2;
		logic [2:0] sel;
		logic [5:0] op;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [15:0] imm;
		last1 = -1;
		last2 = -1;
		for (int i = 0; i < PROG_LEN; i++) begin
			sel = 3'(rand_bits(3));
			case (sel)
				3'd0: op = OP_ADD;
				3'd1: op = OP_SUB;
				3'd2: op = OP_AND;
				3'd3: op = OP_OR;
				3'd4: op = OP_XOR;
				3'd5, 3'd6: op = OP_ADDI;
				default: op = rand_bits(1) != 0 ? OP_UNDEF : OP_NOP;
			endcase
			rd = 5'(rand_bits(5));
			rs1 = pick_source(last1, last2);
			rs2 = pick_source(last1, last2);
			imm = 16'(rand_bits(16));
			if (op == OP_ADDI) begin
				write_inst(i, {op, rd, rs1, imm});
			end else begin
				write_inst(i, {op, rd, rs1, rs2, 11'd0});
			end
			last2 = last1;
			last1 = (op == OP_NOP || op == OP_UNDEF) ? -1 : int'(rd);
		end
		write_inst(PROG_LEN, {OP_HALT, 26'd0});
		// never fetched into issue
		for (int k = 0; k < 3; k++) begin
			cut_rd[k] = 5'(rand_bits(5));
			write_inst(PROG_LEN + 1 + k, {OP_ADDI, cut_rd[k], cut_rd[k], 16'h1357});
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic check_readback();
		logic [7:0] addrs [16];
		logic [31:0] data;
		logic err;
		begin_test();
		for (int i = 0; i < 16; i++) begin
			addrs[i] = 8'(rand_bits(8));
			data = rand_bits(32);
			exp_mem[addrs[i]] = data;
			apb_write({2'b00, addrs[i], 2'b00}, data, err);
			compare("memory readback write pslverr", 32'd0, 32'(err));
		end
		for (int i = 0; i < 16; i++) begin
			apb_read({2'b00, addrs[i], 2'b00}, data, err);
			compare("memory readback data", exp_mem[addrs[i]], data);
			compare("memory readback read pslverr", 32'd0, 32'(err));
		end
		end_test("memory readback");
	endtask

	task automatic check_reset_state();
		logic [31:0] data;
		logic err;
		begin_test();
		check_regs("reset state");
		apb_read(STATUS, data, err);
		compare("reset state status", 32'd0, 32'(data[1:0]));
		compare("reset state status pslverr", 32'd0, 32'(err));
		end_test("reset state");
	endtask

	task automatic run_random_program();
		logic [31:0] data;
		logic err;
		begin_test();
		load_program();
		apb_write(CTRL, 32'd1, err);
		compare("random program start pslverr", 32'd0, 32'(err));
		wait_done();
		run_model();
		// done set, busy clear
		apb_read(STATUS, data, err);
		compare("random program status", 32'd2, 32'(data[1:0]));
		check_regs("random program");
		end_test("random program");
	endtask

	task automatic check_halt_cutoff();
		logic [31:0] data;
		logic err;
		begin_test();
		for (int k = 0; k < 3; k++) begin
			apb_read(REG_WIN + {5'd0, cut_rd[k], 2'b00}, data, err);
			compare($sformatf("halt cuts off r%0d", cut_rd[k]), exp_regs[cut_rd[k]], data);
		end
		end_test("halt cuts off");
	endtask

	task automatic check_error_responses();
		logic [31:0] data;
		logic err;
		begin_test();
		apb_write(CTRL, 32'd1, err);
		compare("error responses start pslverr", 32'd0, 32'(err));
		// still running for a long while
		apb_write(12'h000, {OP_HALT, 26'd0}, err);
		compare("error responses imem write busy", 32'd1, 32'(err));
		apb_write(CTRL, 32'd1, err);
		compare("error responses start busy", 32'd1, 32'(err));
		wait_done();
		run_model();
		apb_write(REG_WIN + 12'h014, 32'hdead_beef, err);
		compare("error responses register write", 32'd1, 32'(err));
		apb_write(UNMAPPED, 32'h0000_0001, err);
		compare("error responses unmapped", 32'd1, 32'(err));
		for (int i = 0; i < PROG_LEN + 4; i++) begin
			apb_read(12'(i * 4), data, err);
			compare($sformatf("error responses imem %0d", i), exp_mem[i], data);
		end
		check_regs("error responses");
		end_test("error responses");
	endtask

	task automatic check_restart();
		logic err;
		begin_test();
		apb_write(CTRL, 32'd1, err);
		compare("restart start pslverr", 32'd0, 32'(err));
		wait_done();
		// starts again from address 0 on the current registers
		run_model();
		check_regs("restart");
		end_test("restart");
	endtask

	initial begin
		lfsr_state = 32'haecb_dc59;
		errors = 0;
		test_start_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 32; i++) begin
			exp_regs[i] = '0;
		end
		rst_n <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		check_readback();
		check_reset_state();
		run_random_program();
		check_halt_cutoff();
		check_error_responses();
		check_restart();

		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* arya.f */
hdl/arya_isa_pkg.sv
hdl/arya_regmap_pkg.sv
hdl/arya_issue_if.sv
hdl/arya_sequencer.sv
hdl/arya_pc_counter.sv
hdl/arya_imem.sv
hdl/arya_regfile.sv
hdl/arya_decode.sv
hdl/arya_execute.sv
hdl/arya.sv
verif/arya_tb.sv

/* Bender.yml */
package:
  name: arya

sources:
  - hdl/arya_isa_pkg.sv
  - hdl/arya_regmap_pkg.sv
  - hdl/arya_issue_if.sv
  - hdl/arya_sequencer.sv
  - hdl/arya_pc_counter.sv
  - hdl/arya_imem.sv
  - hdl/arya_regfile.sv
  - hdl/arya_decode.sv
  - hdl/arya_execute.sv
  - hdl/arya.sv
  - target: simulation
    files:
      - verif/arya_tb.sv
